// File: hw/cpu16_pkg.sv
package cpu16_pkg;

	localparam int DATA_W   = 16;             // datapath and instruction width
	localparam int NUM_REGS = 8;              // r0..r7

	localparam logic [DATA_W-1:0] NOP_INSTRUCTION = 16'h0000;

	localparam logic [2:0] PC_REG = 3'd7;    // program counter
	localparam logic [2:0] LR_REG = 3'd6;    // link register written by bl
	localparam logic [2:0] RR_REG = 3'd5;    // second return register

	// instruction class in bits 15:12
	typedef enum logic [3:0] {
		CLS_MISC    = 4'h0,   // op in 11:8
		CLS_IMM     = 4'h1,   // 12-bit prefix in 11:0
		CLS_ALU_RR  = 4'h2,   // op {3,11:8}, dst 6:4, src 2:0, bit 7 set = flags only
		CLS_ALU_RI  = 4'h3,   // op 11:8, dst 6:4, imm 3:0, bit 7 set = flags only
		CLS_BRANCH  = 4'h4,   // cond 10:8, target {prefix, 3:0}
		CLS_MEM_RR  = 4'h5,   // st 8, inc_b 9, dec_b 10, reg 6:4, index 2:0
		CLS_MEM_IMM = 4'h6,   // st 8, reg 6:4, address {prefix, 3:0}
		CLS_MEM_RRI = 4'h7    // st 8, index 11:9, reg 6:4, offset {prefix, 3:0}
	} op_class_e;

	typedef enum logic [4:0] {
		ALU_MOV = 5'd0,       // y = b, also every unlisted code
		ALU_ADD = 5'd1,
		ALU_ADC = 5'd2,
		ALU_SUB = 5'd3,       // carry holds the borrow
		ALU_SBC = 5'd4,
		ALU_AND = 5'd5,
		ALU_OR  = 5'd6,
		ALU_XOR = 5'd7,
		ALU_SHL = 5'd8,       // a shifted by one
		ALU_SHR = 5'd9
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_Z  = 3'd0,
		BR_NZ = 3'd1,
		BR_S  = 3'd2,
		BR_NS = 3'd3,
		BR_C  = 3'd4,
		BR_NC = 3'd5,
		BR_A  = 3'd6,
		BR_L  = 3'd7          // branch and link to r6
	} branch_cond_e;

	// bits 11:8 of a class 0 word
	typedef enum logic [3:0] {
		MISC_NOP      = 4'h0,
		MISC_RET      = 4'h1, // bit 0 picks r5 over r6
		MISC_INC_MULT = 4'h2, // mask of r0..r6 in 6:0
		MISC_DEC_MULT = 4'h3
	} misc_op_e;

endpackage

// File: hw/pipeline_ctrl.sv
`timescale 1ns/10ps

module pipeline_ctrl import cpu16_pkg::*; (
	input  logic                CLK,
	input  logic                RSTb,
	input  logic [DATA_W-1:0]   mem_rdata,
	input  logic                c,
	input  logic                z,
	input  logic                s,
	output alu_op_e             alu_op,
	output logic                flags_we,
	output logic [DATA_W-1:0]   pout,
	output logic [NUM_REGS-1:0] ld_alu_b,
	output logic [NUM_REGS-1:0] ld_mem_b,
	output logic [NUM_REGS-1:0] ld_pout_b,
	output logic [NUM_REGS-1:0] inc_b,
	output logic [NUM_REGS-1:0] dec_b,
	output logic [2:0]          alu_a_sel,
	output logic [2:0]          alu_b_sel,
	output logic [2:0]          m_sel,
	output logic [2:0]          maddr_sel,
	output logic                m_en_b,
	output logic                maddr_alu_sel_b,
	output logic                maddr_pout_sel_b,
	output logic                alu_b_from_pout_b,
	output logic                mem_oe_b,
	output logic                mem_wr_b
);

	logic [DATA_W-1:0] p0;              // stage 0 word being decoded
	logic [DATA_W-1:0] p0_next;
	logic [DATA_W-1:0] p1;              // stage 1 finishes loads
	logic              stall;           // load data cycle owns the bus
	logic              stall_next;
	logic              delay_slot;      // second bubble after a redirect
	logic              delay_slot_next;
	logic [11:0]       imm;             // prefix for the next word
	logic [11:0]       imm_next;
	logic [3:0]        pout_lo;         // low nibble from the word itself
	logic              redirect;        // pc loads from pout
	op_class_e         cls0;
	op_class_e         cls1;
	logic              mem0;
	logic              mem1_load;

	// active low one-hot register select
	function automatic logic [NUM_REGS-1:0] sel_b(input logic [2:0] idx);
		sel_b = ~(NUM_REGS'(1) << idx);
	endfunction

	function automatic logic branch_taken(input branch_cond_e cond, input logic cf,
		input logic zf, input logic sf);
		case (cond)
			BR_Z:    branch_taken = zf;
			BR_NZ:   branch_taken = !zf;
			BR_S:    branch_taken = sf;
			BR_NS:   branch_taken = !sf;
			BR_C:    branch_taken = cf;       // carry flag proper
			BR_NC:   branch_taken = !cf;
			BR_A:    branch_taken = 1'b1;
			default: branch_taken = 1'b0;     // bl decoded on its own
		endcase
	endfunction

	assign cls0      = op_class_e'(p0[15:12]);
	assign cls1      = op_class_e'(p1[15:12]);
	assign mem0      = cls0 inside {CLS_MEM_RR, CLS_MEM_IMM, CLS_MEM_RRI};
	assign mem1_load = (cls1 inside {CLS_MEM_RR, CLS_MEM_IMM, CLS_MEM_RRI}) && !p1[8];
	assign pout      = {imm, pout_lo};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			p0         <= NOP_INSTRUCTION;
			p1         <= NOP_INSTRUCTION;
			stall      <= 1'b0;
			delay_slot <= 1'b0;
			imm        <= '0;
		end else begin
			p0         <= p0_next;
			p1         <= p0;                 // stage 1 trails by one cycle
			stall      <= stall_next;
			delay_slot <= delay_slot_next;
			imm        <= imm_next;
		end
	end

	always_comb begin
		alu_op            = ALU_MOV;
		flags_we          = 1'b0;
		pout_lo           = 4'h0;
		ld_alu_b          = '1;
		ld_mem_b          = '1;
		ld_pout_b         = '1;
		inc_b             = '1;
		dec_b             = '1;
		alu_a_sel         = '0;
		alu_b_sel         = '0;
		m_sel             = '0;
		maddr_sel         = '0;
		m_en_b            = 1'b1;
		maddr_alu_sel_b   = 1'b1;
		maddr_pout_sel_b  = 1'b1;
		alu_b_from_pout_b = 1'b1;
		mem_oe_b          = 1'b1;
		mem_wr_b          = 1'b1;
		p0_next           = NOP_INSTRUCTION;
		stall_next        = 1'b0;
		delay_slot_next   = 1'b0;
		imm_next          = '0;               // prefix lives for one word
		redirect          = 1'b0;

		if (!stall && !delay_slot) begin
			maddr_sel     = PC_REG;           // fetch at pc
			mem_oe_b      = 1'b0;
			inc_b[PC_REG] = 1'b0;
			p0_next       = mem_rdata;
		end

		if (mem0) begin
			inc_b[PC_REG] = 1'b1;             // hold pc for the refetch
			mem_oe_b      = 1'b1;             // bus goes to the data access
			p0_next       = NOP_INSTRUCTION;
			stall_next    = !p0[8];           // load reads in stage 1
			if (p0[8]) begin
				m_en_b   = 1'b0;              // store source on the bus
				m_sel    = p0[6:4];
				mem_wr_b = 1'b0;
			end
		end

		case (cls0)
			CLS_MISC: begin
				case (misc_op_e'(p0[11:8]))
					MISC_RET: begin
						alu_b_sel       = p0[0] ? RR_REG : LR_REG;
						ld_alu_b        = sel_b(PC_REG);   // pc from alu mov
						inc_b[PC_REG]   = 1'b1;
						p0_next         = NOP_INSTRUCTION; // drop the word in flight
						delay_slot_next = 1'b1;
					end
					MISC_INC_MULT: inc_b[NUM_REGS-2:0] = ~p0[NUM_REGS-2:0];
					MISC_DEC_MULT: dec_b[NUM_REGS-2:0] = ~p0[NUM_REGS-2:0];
					default: ;
				endcase
			end
			CLS_IMM: imm_next = p0[11:0];
			CLS_ALU_RR: begin
				alu_op    = alu_op_e'({p0[3], p0[11:8]});
				alu_a_sel = p0[6:4];
				alu_b_sel = p0[2:0];
				flags_we  = 1'b1;
				if (!p0[7])
					ld_alu_b = sel_b(p0[6:4]);    // write back unless compare
			end
			CLS_ALU_RI: begin
				alu_op            = alu_op_e'({1'b0, p0[11:8]});
				pout_lo           = p0[3:0];
				alu_a_sel         = p0[6:4];
				alu_b_from_pout_b = 1'b0;         // b is the constant
				flags_we          = 1'b1;
				if (!p0[7])
					ld_alu_b = sel_b(p0[6:4]);
			end
			CLS_BRANCH: begin
				if (branch_cond_e'(p0[10:8]) == BR_L) begin
					alu_b_sel = PC_REG;           // pc already past the bl
					ld_alu_b  = sel_b(LR_REG);
					redirect  = 1'b1;
				end else begin
					redirect = branch_taken(branch_cond_e'(p0[10:8]), c, z, s);
				end
			end
			CLS_MEM_RR: begin
				if (p0[8]) begin
					maddr_sel         = p0[2:0];  // address from index reg
					inc_b[p0[2:0]]    = p0[9];    // post increment
					dec_b[p0[2:0]]    = p0[10];   // post decrement
				end
			end
			CLS_MEM_IMM: begin
				pout_lo          = p0[3:0];
				maddr_pout_sel_b = 1'b0;
				if (!p0[8])
					imm_next = imm;               // keep prefix for stage 1
			end
			CLS_MEM_RRI: begin
				alu_op            = ALU_ADD;      // index plus offset
				alu_a_sel         = p0[11:9];
				alu_b_from_pout_b = 1'b0;
				maddr_alu_sel_b   = 1'b0;
				pout_lo           = p0[3:0];
				if (!p0[8])
					imm_next = imm;
			end
			default: ;
		endcase

		if (redirect) begin
			pout_lo         = p0[3:0];            // absolute target
			ld_pout_b       = sel_b(PC_REG);
			inc_b[PC_REG]   = 1'b1;
			p0_next         = NOP_INSTRUCTION;
			delay_slot_next = 1'b1;
		end

		// stage 0 holds a bubble here so the bus is free
		if (mem1_load) begin
			mem_oe_b = 1'b0;
			ld_mem_b = sel_b(p1[6:4]);            // write back from memory
			case (cls1)
				CLS_MEM_RR: begin
					maddr_sel      = p1[2:0];
					inc_b[p1[2:0]] = p1[9];
					dec_b[p1[2:0]] = p1[10];
				end
				CLS_MEM_IMM: begin
					pout_lo          = p1[3:0];
					maddr_pout_sel_b = 1'b0;
				end
				default: begin
					alu_op            = ALU_ADD;  // reg plus immediate address
					alu_a_sel         = p1[11:9];
					alu_b_from_pout_b = 1'b0;
					maddr_alu_sel_b   = 1'b0;
					pout_lo           = p1[3:0];
				end
			endcase
		end
	end

endmodule

// File: hw/register_file.sv
`timescale 1ns/10ps

module register_file import cpu16_pkg::*; (
	input  logic                CLK,
	input  logic                RSTb,
	input  logic [DATA_W-1:0]   alu_y,
	input  logic [DATA_W-1:0]   mem_rdata,
	input  logic [DATA_W-1:0]   pout,
	input  logic [NUM_REGS-1:0] ld_alu_b,   // active low per register
	input  logic [NUM_REGS-1:0] ld_mem_b,
	input  logic [NUM_REGS-1:0] ld_pout_b,
	input  logic [NUM_REGS-1:0] inc_b,
	input  logic [NUM_REGS-1:0] dec_b,
	input  logic [2:0]          alu_a_sel,
	input  logic [2:0]          alu_b_sel,
	input  logic [2:0]          m_sel,
	input  logic [2:0]          maddr_sel,
	output logic [DATA_W-1:0]   rd_a,
	output logic [DATA_W-1:0]   rd_b,
	output logic [DATA_W-1:0]   rd_m,
	output logic [DATA_W-1:0]   rd_addr
);

	logic [DATA_W-1:0] regs [NUM_REGS];     // r7 is the pc

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;                  // pc starts at 0
			end
		end else begin
			for (int i = 0; i < NUM_REGS; i++) begin
				if (!ld_alu_b[i]) begin
					regs[i] <= alu_y;           // alu wins
				end else if (!ld_mem_b[i]) begin
					regs[i] <= mem_rdata;
				end else if (!ld_pout_b[i]) begin
					regs[i] <= pout;            // constants and branch targets
				end else if (!inc_b[i]) begin
					regs[i] <= regs[i] + 1'b1;
				end else if (!dec_b[i]) begin
					regs[i] <= regs[i] - 1'b1;
				end
			end
		end
	end

	// combinational read ports
	assign rd_a    = regs[alu_a_sel];
	assign rd_b    = regs[alu_b_sel];
	assign rd_m    = regs[m_sel];          // store data
	assign rd_addr = regs[maddr_sel];      // fetch or index address

endmodule

// File: hw/alu16.sv
`timescale 1ns/10ps

module alu16 import cpu16_pkg::*; (
	input  logic              CLK,
	input  logic              RSTb,
	input  alu_op_e           alu_op,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic              flags_we,    // alu classes only
	output logic [DATA_W-1:0] y,
	output logic              c,
	output logic              z,
	output logic              s
);

	logic [DATA_W:0] res;                  // carry or borrow in the top bit
	logic [DATA_W:0] cin;

	assign cin = {{DATA_W{1'b0}}, c};

	always_comb begin
		case (alu_op)
			ALU_ADD: res = {1'b0, a} + {1'b0, b};
			ALU_ADC: res = {1'b0, a} + {1'b0, b} + cin;
			ALU_SUB: res = {1'b0, a} - {1'b0, b};          // borrow out
			ALU_SBC: res = {1'b0, a} - {1'b0, b} - cin;
			ALU_AND: res = {1'b0, a & b};                  // carry cleared
			ALU_OR:  res = {1'b0, a | b};
			ALU_XOR: res = {1'b0, a ^ b};
			ALU_SHL: res = {a, 1'b0};                       // msb into carry
			ALU_SHR: res = {a[0], 1'b0, a[DATA_W-1:1]};     // lsb into carry
			default: res = {1'b0, b};                       // mov
		endcase
	end

	assign y = res[DATA_W-1:0];

	// flags change on the same edge as the result write
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			c <= 1'b0;
			z <= 1'b0;
			s <= 1'b0;
		end else if (flags_we) begin
			c <= res[DATA_W];
			z <= (y == '0);
			s <= y[DATA_W-1];
		end
	end

endmodule

// File: hw/bus_select.sv
`timescale 1ns/10ps

module bus_select import cpu16_pkg::*; (
	input  logic [DATA_W-1:0] rd_b,
	input  logic [DATA_W-1:0] rd_m,
	input  logic [DATA_W-1:0] rd_addr,
	input  logic [DATA_W-1:0] alu_y,
	input  logic [DATA_W-1:0] pout,
	input  logic              alu_b_from_pout_b,   // low picks the constant
	input  logic              maddr_alu_sel_b,     // reg plus offset address
	input  logic              maddr_pout_sel_b,    // absolute address
	input  logic              m_en_b,              // store data enable
	output logic [DATA_W-1:0] alu_b,
	output logic [DATA_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata
);

	assign alu_b = alu_b_from_pout_b ? rd_b : pout;

	// alu sum first, then pout, else the selected register
	always_comb begin
		if (!maddr_alu_sel_b) begin
			mem_addr = alu_y;
		end else if (!maddr_pout_sel_b) begin
			mem_addr = pout;
		end else begin
			mem_addr = rd_addr;                        // pc on fetch
		end
	end

	assign mem_wdata = m_en_b ? '0 : rd_m;             // quiet bus when idle

endmodule

// File: hw/cpu16_top.sv
`timescale 1ns/10ps

module cpu16_top import cpu16_pkg::*; (
	input  logic              CLK,
	input  logic              RSTb,
	input  logic [DATA_W-1:0] mem_rdata,
	output logic [DATA_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	output logic              mem_oe_b,
	output logic              mem_wr_b
);

	alu_op_e             alu_op;
	logic                flags_we;
	logic [DATA_W-1:0]   pout;
	logic [NUM_REGS-1:0] ld_alu_b;
	logic [NUM_REGS-1:0] ld_mem_b;
	logic [NUM_REGS-1:0] ld_pout_b;
	logic [NUM_REGS-1:0] inc_b;
	logic [NUM_REGS-1:0] dec_b;
	logic [2:0]          alu_a_sel;
	logic [2:0]          alu_b_sel;
	logic [2:0]          m_sel;
	logic [2:0]          maddr_sel;
	logic                m_en_b;
	logic                maddr_alu_sel_b;
	logic                maddr_pout_sel_b;
	logic                alu_b_from_pout_b;
	logic                c;
	logic                z;
	logic                s;
	logic [DATA_W-1:0]   alu_y;
	logic [DATA_W-1:0]   alu_b;
	logic [DATA_W-1:0]   rd_a;
	logic [DATA_W-1:0]   rd_b;
	logic [DATA_W-1:0]   rd_m;
	logic [DATA_W-1:0]   rd_addr;

	pipeline_ctrl i_pipeline_ctrl (.*);    // decode

	register_file i_register_file (.*);

	alu16 i_alu16 (
		.a (rd_a),
		.b (alu_b),                        // register or constant
		.y (alu_y),
		.*
	);

	bus_select i_bus_select (.*);          // operand and memory buses

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic CLK,
	output logic RSTb
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;              // 10 ns period
	end

	initial begin
		RSTb = 1'b0;
		repeat (5) @(posedge CLK);          // five cycles in reset
		RSTb <= 1'b1;
	end

endmodule

// File: sim/cpu16_assertions.sv
`timescale 1ns/10ps

module cpu16_assertions (
	input logic       CLK,
	input logic       RSTb,
	input logic       mem_oe_b,
	input logic       mem_wr_b,
	input logic       m_en_b,
	input logic [7:0] ld_alu_b,
	input logic [7:0] ld_mem_b,
	input logic [7:0] ld_pout_b
);

	strobes_exclusive: assert property (@(posedge CLK) disable iff (!RSTb)
		!(!mem_oe_b && !mem_wr_b))
		else $error("output enable and write strobe low together");

	store_data_with_write: assert property (@(posedge CLK) disable iff (!RSTb)
		!m_en_b |-> !mem_wr_b)
		else $error("store data driven without a write strobe");

	one_load_source: assert property (@(posedge CLK) disable iff (!RSTb)
		((~ld_alu_b & ~ld_mem_b) | (~ld_alu_b & ~ld_pout_b) | (~ld_mem_b & ~ld_pout_b)) == 8'h00)
		else $error("a register is loaded from two sources");

	// quiet during reset and the cycle after it
	quiet_after_reset: assert property (@(posedge CLK)
		!RSTb |=> (&ld_alu_b && &ld_mem_b && &ld_pout_b && mem_wr_b && m_en_b))
		else $error("load or write strobe active after reset");

endmodule

bind pipeline_ctrl cpu16_assertions i_cpu16_assertions (.*);

// File: sim/cpu16_tb.sv
`timescale 1ns/10ps

module cpu16_tb import cpu16_pkg::*; ();

	logic        CLK;
	logic        RSTb;
	logic [15:0] mem_rdata;
	logic [15:0] mem_addr;
	logic [15:0] mem_wdata;
	logic        mem_oe_b;
	logic        mem_wr_b;
	logic [15:0] mem [256];                  // program and data
	logic [15:0] lfsr;
	logic [15:0] exp_addr [$];               // expected store sequence
	logic [15:0] exp_data [$];
	logic [15:0] ea;
	logic [15:0] ed;
	int          wp;                         // program write pointer
	int          errors = 0;
	int          cycles = 0;
	int          steps;
	int          limit;
	bit          done = 1'b0;

	tb_clock i_tb_clock (.CLK(CLK), .RSTb(RSTb));

	cpu16_top i_cpu16_top (.*);

	// async read, bus floats to ones without output enable
	assign mem_rdata = mem_oe_b ? 16'hFFFF : mem[mem_addr[7:0]];

	always @(posedge CLK) begin
		if (!mem_wr_b)
			mem[mem_addr[7:0]] <= mem_wdata;
	end

	// fibonacci lfsr x^16+x^14+x^13+x^11 stepped once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[14:0], fb};
		end
		return v;
	endfunction

	task automatic emit(input logic [15:0] w);
		mem[wp[7:0]] = w;
		wp++;
	endtask

	task automatic prefix(input logic [11:0] v);
		emit({4'h1, v});
	endtask

	task automatic set_reg(input logic [2:0] rd, input logic [15:0] v);
		prefix(v[15:4]);
		emit({4'h3, 4'(ALU_MOV), 1'b0, rd, v[3:0]});   // mov of the constant
	endtask

	task automatic alu_rr(input logic [4:0] op, input logic [2:0] rd, input logic [2:0] rs,
		input logic cmp);
		emit({4'h2, op[3:0], cmp, rd, op[4], rs});
	endtask

	task automatic alu_ri(input logic [3:0] op, input logic [2:0] rd, input logic [3:0] k,
		input logic cmp);
		emit({4'h3, op, cmp, rd, k});
	endtask

	task automatic branch(input logic [2:0] cond, input logic [15:0] target);
		prefix(target[15:4]);                      // always two words
		emit({4'h4, 1'b0, cond, 4'h0, target[3:0]});
	endtask

	task automatic misc(input logic [3:0] op, input logic [6:0] arg);
		emit({4'h0, op, 1'b0, arg});
	endtask

	task automatic mem_rr(input logic st, input logic [2:0] rd, input logic [2:0] idx,
		input logic inc, input logic dec);
		emit({4'h5, 1'b0, !dec, !inc, st, 1'b0, rd, 1'b0, idx});
	endtask

	task automatic mem_abs(input logic st, input logic [2:0] rd, input logic [15:0] addr);
		prefix(addr[15:4]);
		emit({4'h6, 3'b000, st, 1'b0, rd, addr[3:0]});
	endtask

	task automatic mem_rri(input logic st, input logic [2:0] rd, input logic [2:0] idx,
		input logic [15:0] off);
		prefix(off[15:4]);
		emit({4'h7, idx, st, 1'b0, rd, off[3:0]});
	endtask

	// r0..r5 to e0..e5 through r6 with post increment
	task automatic store_regs();
		set_reg(3'd6, 16'h00E0);
		for (int k = 0; k < 6; k++)
			mem_rr(1'b1, 3'(k), 3'd6, 1'b1, 1'b0);
	endtask

	task automatic build_program();
		int t;
		wp = 0;
		for (int k = 0; k < 5; k++)
			set_reg(3'(k), rand_bits(16));           // random operands
		for (int k = 0; k < 6; k++) begin
			if (rand_bits(1))
				alu_rr(5'(rand_bits(5)), 3'(rand_bits(2)), 3'(rand_bits(2)),
					1'(rand_bits(1)));
			else
				alu_ri(4'(rand_bits(4)), 3'(rand_bits(2)), 4'(rand_bits(4)),
					1'(rand_bits(1)));
			store_regs();
		end
		mem_abs(1'b1, 3'd0, 16'h00F0);              // absolute address via prefix
		set_reg(3'd3, 16'h0000);
		set_reg(3'd4, 16'h0001);
		for (int cond = 0; cond < 7; cond++) begin
			for (int st = 0; st < 2; st++) begin
				alu_rr(ALU_SUB, 3'd3, st ? 3'd4 : 3'd3, 1'b1);  // z only or s and c
				branch(3'(cond), 16'(wp + 3));     // skip the marker
				misc(MISC_INC_MULT, 7'(1 << (cond % 3)));
			end
		end
		store_regs();
		t = wp;
		branch(BR_L, 16'(t + 5));                   // call
		misc(MISC_INC_MULT, 7'b0000001);
		branch(BR_A, 16'(t + 7));                   // over the subroutine
		misc(MISC_INC_MULT, 7'b0000010);            // subroutine body
		misc(MISC_RET, 7'd0);
		t = wp;
		set_reg(3'd5, 16'(t + 4));
		misc(MISC_RET, 7'd1);                       // return through r5
		misc(MISC_INC_MULT, 7'b0000100);            // never runs
		mem_abs(1'b1, 3'd6, 16'h00F1);
		store_regs();
		for (int k = 0; k < 3; k++)
			set_reg(3'(k), rand_bits(16));
		set_reg(3'd3, 16'h00F4);
		mem_rr(1'b1, 3'd0, 3'd3, 1'b1, 1'b0);
		mem_rr(1'b1, 3'd1, 3'd3, 1'b0, 1'b1);
		mem_rr(1'b1, 3'd2, 3'd3, 1'b0, 1'b0);
		mem_rri(1'b1, 3'd1, 3'd3, 16'h0003);
		mem_rr(1'b0, 3'd4, 3'd3, 1'b0, 1'b1);
		mem_abs(1'b0, 3'd5, 16'h00F5);
		mem_rri(1'b0, 3'd0, 3'd3, 16'h0002);
		mem_rr(1'b0, 3'd1, 3'd3, 1'b1, 1'b0);       // reads the fill pattern
		store_regs();
		misc(MISC_INC_MULT, 7'(rand_bits(7)));
		misc(MISC_DEC_MULT, 7'(rand_bits(7)));
		store_regs();
		mem_abs(1'b1, 3'd0, 16'h00FF);              // end marker
		branch(BR_A, 16'(wp));                      // park on itself
	endtask

	function automatic logic [16:0] alu_ref(input logic [4:0] op, input logic [15:0] a,
		input logic [15:0] b, input logic cin);
		int unsigned ua;
		int unsigned ub;
		int unsigned ci;
		ua = 32'(a);
		ub = 32'(b);
		ci = 32'(cin);
		case (op)
			ALU_ADD: return 17'(ua + ub);                      // carry out in bit 16
			ALU_ADC: return 17'(ua + ub + ci);
			ALU_SUB: return {ua < ub, 16'(ua - ub)};           // borrow when b exceeds a
			ALU_SBC: return {ua < ub + ci, 16'(ua - ub - ci)};
			ALU_AND: return {1'b0, a & b};
			ALU_OR:  return {1'b0, a | b};
			ALU_XOR: return {1'b0, a ^ b};
			ALU_SHL: return {a[15], a << 1};
			ALU_SHR: return {a[0], a >> 1};
			default: return {1'b0, b};                          // mov for other codes
		endcase
	endfunction

	// instruction level model filling the expected store queues
	function automatic int run_reference();
		logic [15:0] m [256];
		logic [15:0] r [8];
		logic [15:0] w;
		logic [15:0] v;
		logic [15:0] adr;
		logic [15:0] d;
		logic [16:0] res;
		logic [11:0] pre;
		logic        c;
		logic        z;
		logic        s;
		logic        tk;
		int          n;
		bit          fin;
		for (int i = 0; i < 256; i++)
			m[i] = mem[i];
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		pre = '0;
		c = 1'b0;
		z = 1'b0;
		s = 1'b0;
		n = 0;
		fin = 0;
		while (!fin && n < 4000) begin
			w = m[r[7][7:0]];
			r[7]++;                               // pc reads as next address
			n++;
			v = {pre, w[3:0]};                    // prefix lasts one word
			pre = '0;
			case (w[15:12])
				4'h0: begin
					case (w[11:8])
						4'h1: r[7] = w[0] ? r[5] : r[6];
						4'h2: begin
							for (int k = 0; k < 7; k++) begin
								if (w[k])
									r[k]++;
							end
						end
						4'h3: begin
							for (int k = 0; k < 7; k++) begin
								if (w[k])
									r[k]--;
							end
						end
						default: ;
					endcase
				end
				4'h1: pre = w[11:0];
				4'h2, 4'h3: begin
					if (w[12])
						res = alu_ref({1'b0, w[11:8]}, r[w[6:4]], v, c);
					else
						res = alu_ref({w[3], w[11:8]}, r[w[6:4]], r[w[2:0]], c);
					if (!w[7])
						r[w[6:4]] = res[15:0];
					c = res[16];
					z = (res[15:0] == 16'h0000);
					s = res[15];
				end
				4'h4: begin
					case (w[10:8])
						3'd0: tk = z;
						3'd1: tk = !z;
						3'd2: tk = s;
						3'd3: tk = !s;
						3'd4: tk = c;
						3'd5: tk = !c;
						default: tk = 1'b1;
					endcase
					if (w[10:8] == 3'd7)
						r[6] = r[7];                  // link
					if (tk)
						r[7] = v;
				end
				4'h5, 4'h6, 4'h7: begin
					if (w[15:12] == 4'h5)
						adr = r[w[2:0]];
					else if (w[15:12] == 4'h6)
						adr = v;
					else
						adr = r[w[11:9]] + v;
					if (w[8]) begin
						d = r[w[6:4]];
						exp_addr.push_back(adr);
						exp_data.push_back(d);
						m[adr[7:0]] = d;
						fin = (adr == 16'h00FF);
					end else begin
						d = m[adr[7:0]];
					end
					if (w[15:12] == 4'h5 && !w[9])
						r[w[2:0]]++;
					else if (w[15:12] == 4'h5 && !w[10])
						r[w[2:0]]--;
					if (!w[8])
						r[w[6:4]] = d;                // loaded value wins
				end
				default: ;
			endcase
		end
		return n;
	endfunction

	// store compare
	always @(posedge CLK) begin
		if (RSTb)
			cycles <= cycles + 1;
		if (RSTb && !mem_wr_b) begin
			assert (exp_addr.size() != 0) else begin
				$display("%0t: the DUT stored to %h after the last expected store",
					$time, mem_addr);
				errors++;
			end
			if (exp_addr.size() != 0) begin
				ea = exp_addr.pop_front();
				ed = exp_data.pop_front();
				assert (mem_addr == ea) else begin
					$display("[FAIL] %0t mem_addr got %h expected %h", $time, mem_addr, ea);
					errors++;
				end
				assert (mem_wdata == ed) else begin
					$display("[FAIL] %0t mem_wdata got %h expected %h", $time, mem_wdata, ed);
					errors++;
				end
				if (ea == 16'h00FF)
					done = 1;
			end
		end
	end

	initial begin
		lfsr = 16'd15;
		for (int i = 0; i < 256; i++)
			mem[i] = {8'(~i), 8'(i)};              // address tagged fill
		build_program();
		steps = run_reference();
		limit = 4 * steps + 50;
		wait (RSTb);
		while (!done && cycles < limit)
			@(posedge CLK);
		if (!done)
			$display("timeout: the end store to address 00ff never came in %0d cycles", cycles);
		$display("stores left %0d, errors %0d", exp_addr.size(), errors);
		if (errors == 0 && done)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: cpu16.f
hw/cpu16_pkg.sv
hw/pipeline_ctrl.sv
hw/register_file.sv
hw/alu16.sv
hw/bus_select.sv
hw/cpu16_top.sv
sim/tb_clock.sv
sim/cpu16_assertions.sv
sim/cpu16_tb.sv

// File: Makefile
TOP = cpu16_tb

all: run

build:
	verilator --binary --timing --assert -f cpu16.f --top-module $(TOP) -Mdir obj_dir -o sim_cpu16

run: build
	./obj_dir/sim_cpu16 > sim.log 2>&1; cat sim.log
	@grep -q "STATUS: PASS" sim.log && ! grep -q "STATUS: FAIL" sim.log

lint:
	verilator --lint-only --timing -f cpu16.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
